// File: source/xt_glue_pkg.sv
// ----------------------------------------
// XT glue shared definitions
// Bus widths, port addresses, EMS constants
// and the packed types of the glue block
// ----------------------------------------
package xt_glue_pkg;

    localparam int ADDR_W     = 20;
    localparam int DATA_W     = 8;
    localparam int EMS_PAGES  = 4;
    localparam int EMS_PAGE_W = 7;

    // I/O ports, low 16 address bits
    localparam logic [15:0] EMS_PORT_BASE = 16'h0260;
    localparam logic [15:0] LPT_PORT      = 16'h0378;
    localparam logic [15:0] NMI_MASK_BASE = 16'h00A0;

    localparam logic [DATA_W-1:0] LPT_RESET        = 8'hFF;
    localparam logic [DATA_W-1:0] NMI_MASK_RESET   = 8'hFF;
    localparam logic [DATA_W-1:0] EMS_DISABLE_CODE = 8'hFF;

    // Segment tops of the EMS frame
    localparam logic [3:0] EMS_FRAME_A = 4'hA;
    localparam logic [3:0] EMS_FRAME_C = 4'hC;
    localparam logic [3:0] EMS_FRAME_D = 4'hD;

    typedef struct packed {
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] write_data;
        logic              io_read_n;
        logic              io_write_n;
        logic              address_enable_n;
    } bus_cycle_t;

    typedef struct packed {
        logic dma_n;
        logic pic_n;
        logic pit_n;
        logic ppi_n;
        logic dma_page_n;
    } io_select_t;

    typedef struct packed {
        logic                  enable;
        logic [EMS_PAGE_W-1:0] page;
    } ems_map_t;

    // Written byte, seen raw or as no-page flag plus page number
    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic                  no_page;
            logic [EMS_PAGE_W-1:0] page;
        } fields;
    } ems_write_u;

endpackage

// File: source/xt_io_decoder.sv
// ----------------------------------------
// XT I/O decoder
// Low-space chip selects and the read and
// write enables of the glue registers
// ----------------------------------------
`timescale 1ns/1ns

module xt_io_decoder (
    input  xt_glue_pkg::bus_cycle_t bus_i,
    input  logic                    tandy_video_i,
    input  logic                    ems_enabled_i,
    output xt_glue_pkg::io_select_t selects_o,
    output logic                    ems_write_o,
    output logic                    ems_read_o,
    output logic [1:0]              ems_index_o,
    output logic                    lpt_write_o,
    output logic                    lpt_read_o,
    output logic                    nmi_write_o,
    output logic                    nmi_read_o
);
    import xt_glue_pkg::*;

    logic io_strobe;
    logic low_space;
    logic ems_match;
    logic lpt_match;
    logic nmi_match;

    assign io_strobe = ~bus_i.io_read_n | ~bus_i.io_write_n;
    assign low_space = ~bus_i.address_enable_n & ~bus_i.address[9] & ~bus_i.address[8]
                       & io_strobe;

    // One 32-byte block per device, upper three blocks unused
    always_comb begin
        selects_o = '1;
        if (low_space) begin
            case (bus_i.address[7:5])
                3'd0:    selects_o.dma_n      = 1'b0;
                3'd1:    selects_o.pic_n      = 1'b0;
                3'd2:    selects_o.pit_n      = 1'b0;
                3'd3:    selects_o.ppi_n      = 1'b0;
                3'd4:    selects_o.dma_page_n = 1'b0;
                default: selects_o            = '1;
            endcase
        end
    end

    assign ems_match = ~bus_i.address_enable_n & ems_enabled_i
                       & (bus_i.address[15:2] == EMS_PORT_BASE[15:2]);
    assign lpt_match = ~bus_i.address_enable_n & (bus_i.address[15:0] == LPT_PORT);
    // A0h to A7h only exists on Tandy
    assign nmi_match = ~bus_i.address_enable_n & tandy_video_i
                       & (bus_i.address[15:3] == NMI_MASK_BASE[15:3]);

    assign ems_write_o = ems_match & ~bus_i.io_write_n;
    assign ems_read_o  = ems_match & ~bus_i.io_read_n;
    assign ems_index_o = bus_i.address[1:0];
    assign lpt_write_o = lpt_match & ~bus_i.io_write_n;
    assign lpt_read_o  = lpt_match & ~bus_i.io_read_n;
    assign nmi_write_o = nmi_match & ~bus_i.io_write_n;
    assign nmi_read_o  = nmi_match & ~bus_i.io_read_n;

endmodule

// File: source/xt_ems_mapper.sv
// ----------------------------------------
// EMS page mapper
// Four page-map registers at 260h-263h and
// the memory-window hits of the EMS frame
// ----------------------------------------
`timescale 1ns/1ns

module xt_ems_mapper (
    input  logic                                              clock,
    input  logic                                              reset,
    input  logic                                              ems_write_i,
    input  logic                                              ems_read_i,
    input  logic [1:0]                                        ems_index_i,
    input  logic [xt_glue_pkg::DATA_W-1:0]                    write_data_i,
    input  logic [xt_glue_pkg::ADDR_W-1:0]                    address_i,
    input  logic [1:0]                                        ems_frame_i,
    input  logic                                              io_cycle_i,
    output xt_glue_pkg::ems_map_t [xt_glue_pkg::EMS_PAGES-1:0] ems_map_o,
    output logic [xt_glue_pkg::DATA_W-1:0]                    ems_read_data_o,
    output logic [xt_glue_pkg::EMS_PAGES-1:0]                 ems_window_o
);
    import xt_glue_pkg::*;

    ems_write_u                  wr_byte;
    ems_map_t                    wr_entry;
    logic                        wr_update;
    logic                        wr_valid_q;
    logic [1:0]                  wr_index_q;
    ems_map_t                    wr_entry_q;
    ems_map_t [EMS_PAGES-1:0]    map_q;
    logic [3:0]                  frame_top;

    // Decode the written byte; other bytes above 7Fh leave the entry alone
    always_comb begin
        wr_byte  = write_data_i;
        wr_entry = '{enable: 1'b1, page: wr_byte.fields.page};
        if (wr_byte.raw == EMS_DISABLE_CODE) begin
            wr_entry = '{enable: 1'b0, page: '1};
        end
        wr_update = (wr_byte.raw == EMS_DISABLE_CODE) | ~wr_byte.fields.no_page;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_valid_q <= 1'b0;
        end else begin
            wr_valid_q <= ems_write_i & wr_update;
        end
    end

    always_ff @(posedge clock) begin
        wr_index_q <= ems_index_i;
        wr_entry_q <= wr_entry;
    end

    // Second stage lands the registered entry in the map
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            map_q <= '0;
        end else if (wr_valid_q) begin
            map_q[wr_index_q] <= wr_entry_q;
        end
    end

    assign frame_top = (ems_frame_i == 2'b00) ? EMS_FRAME_A :
                       (ems_frame_i == 2'b01) ? EMS_FRAME_C : EMS_FRAME_D;

    // 16 KB windows at top:00, top:01, top:10, top:11
    always_comb begin
        for (int k = 0; k < EMS_PAGES; k++) begin
            ems_window_o[k] = ~io_cycle_i & map_q[k].enable
                              & (address_i[19:14] == {frame_top, 2'(k)});
        end
    end

    assign ems_map_o       = map_q;
    assign ems_read_data_o = ~ems_read_i                   ? '0 :
                             map_q[ems_index_i].enable     ? {1'b0, map_q[ems_index_i].page} :
                                                             EMS_DISABLE_CODE;

    map_change_needs_write: assert property (
        @(posedge clock) disable iff (reset)
        (map_q != $past(map_q)) |-> $past(wr_valid_q)
    ) else $error("EMS map changed without a registered write");

endmodule

// File: source/xt_port_registers.sv
// ----------------------------------------
// Port registers
// Parallel-port latch at 378h and the
// Tandy NMI-mask register
// ----------------------------------------
`timescale 1ns/1ns

module xt_port_registers (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           lpt_write_i,
    input  logic                           nmi_write_i,
    input  logic [xt_glue_pkg::DATA_W-1:0] write_data_i,
    output logic [xt_glue_pkg::DATA_W-1:0] lpt_data_o,
    output logic [xt_glue_pkg::DATA_W-1:0] nmi_mask_o
);
    import xt_glue_pkg::*;

    logic [DATA_W-1:0] lpt_q;
    logic [DATA_W-1:0] nmi_mask_q;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_q <= LPT_RESET;
        end else if (lpt_write_i) begin
            lpt_q <= write_data_i;
        end
    end

    // Bit 7 gates NMI, bits 3 to 1 pick the video page on Tandy
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            nmi_mask_q <= NMI_MASK_RESET;
        end else if (nmi_write_i) begin
            nmi_mask_q <= write_data_i;
        end
    end

    assign lpt_data_o = lpt_q;
    assign nmi_mask_o = nmi_mask_q;

endmodule

// File: source/xt_bus_readback.sv
// ----------------------------------------
// Bus read-back
// Registered priority mux of the glue
// registers onto the outgoing data bus
// ----------------------------------------
`timescale 1ns/1ns

module xt_bus_readback (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           ems_read_i,
    input  logic                           lpt_read_i,
    input  logic                           nmi_read_i,
    input  logic [xt_glue_pkg::DATA_W-1:0] ems_read_data_i,
    input  logic [xt_glue_pkg::DATA_W-1:0] lpt_data_i,
    input  logic [xt_glue_pkg::DATA_W-1:0] nmi_mask_i,
    output logic [xt_glue_pkg::DATA_W-1:0] data_o,
    output logic                           data_valid_o
);

    // EMS first, then LPT, then NMI mask
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_o       <= '0;
            data_valid_o <= 1'b0;
        end else if (ems_read_i) begin
            data_o       <= ems_read_data_i;
            data_valid_o <= 1'b1;
        end else if (lpt_read_i) begin
            data_o       <= lpt_data_i;
            data_valid_o <= 1'b1;
        end else if (nmi_read_i) begin
            data_o       <= nmi_mask_i;
            data_valid_o <= 1'b1;
        end else begin
            // Nothing of ours on the bus
            data_o       <= '0;
            data_valid_o <= 1'b0;
        end
    end

    valid_needs_read: assert property (
        @(posedge clock) disable iff (reset)
        data_valid_o |-> $past(ems_read_i | lpt_read_i | nmi_read_i)
    ) else $error("read-back valid without a read strobe");

endmodule

// File: source/xt_glue_top.sv
// ----------------------------------------
// XT glue top level
// Connects the I/O decoder to the EMS
// mapper, port registers and read-back
// ----------------------------------------
`timescale 1ns/1ns

module xt_glue_top (
    input  logic                                              clock,
    input  logic                                              reset,
    input  xt_glue_pkg::bus_cycle_t                           bus_i,
    input  logic                                              tandy_video_i,
    input  logic                                              ems_enabled_i,
    input  logic [1:0]                                        ems_frame_i,
    output xt_glue_pkg::io_select_t                           selects_o,
    output xt_glue_pkg::ems_map_t [xt_glue_pkg::EMS_PAGES-1:0] ems_map_o,
    output logic [xt_glue_pkg::EMS_PAGES-1:0]                 ems_window_o,
    output logic [xt_glue_pkg::DATA_W-1:0]                    data_o,
    output logic                                              data_valid_o
);
    import xt_glue_pkg::*;

    logic              ems_write;
    logic              ems_read;
    logic [1:0]        ems_index;
    logic              lpt_write;
    logic              lpt_read;
    logic              nmi_write;
    logic              nmi_read;
    logic              io_cycle;
    logic [DATA_W-1:0] ems_read_data;
    logic [DATA_W-1:0] lpt_data;
    logic [DATA_W-1:0] nmi_mask;

    // Any I/O strobe marks the cycle as I/O rather than memory
    assign io_cycle = ~bus_i.io_read_n | ~bus_i.io_write_n;

    xt_io_decoder u_decoder (
        .bus_i         (bus_i),
        .tandy_video_i (tandy_video_i),
        .ems_enabled_i (ems_enabled_i),
        .selects_o     (selects_o),
        .ems_write_o   (ems_write),
        .ems_read_o    (ems_read),
        .ems_index_o   (ems_index),
        .lpt_write_o   (lpt_write),
        .lpt_read_o    (lpt_read),
        .nmi_write_o   (nmi_write),
        .nmi_read_o    (nmi_read)
    );

    xt_ems_mapper u_ems_mapper (
        .clock           (clock),
        .reset           (reset),
        .ems_write_i     (ems_write),
        .ems_read_i      (ems_read),
        .ems_index_i     (ems_index),
        .write_data_i    (bus_i.write_data),
        .address_i       (bus_i.address),
        .ems_frame_i     (ems_frame_i),
        .io_cycle_i      (io_cycle),
        .ems_map_o       (ems_map_o),
        .ems_read_data_o (ems_read_data),
        .ems_window_o    (ems_window_o)
    );

    xt_port_registers u_port_registers (
        .clock        (clock),
        .reset        (reset),
        .lpt_write_i  (lpt_write),
        .nmi_write_i  (nmi_write),
        .write_data_i (bus_i.write_data),
        .lpt_data_o   (lpt_data),
        .nmi_mask_o   (nmi_mask)
    );

    xt_bus_readback u_readback (
        .clock           (clock),
        .reset           (reset),
        .ems_read_i      (ems_read),
        .lpt_read_i      (lpt_read),
        .nmi_read_i      (nmi_read),
        .ems_read_data_i (ems_read_data),
        .lpt_data_i      (lpt_data),
        .nmi_mask_i      (nmi_mask),
        .data_o          (data_o),
        .data_valid_o    (data_valid_o)
    );

endmodule

// File: test/tb_clock_gen.sv
// ----------------------------------------
// Testbench clock and reset
// 8 ns clock, reset held for 10 cycles
// ----------------------------------------
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever #4 clock_o = ~clock_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (10) @(posedge clock_o);
        reset_o <= 1'b0;
    end

endmodule

// File: test/tb_xt_glue.sv
// ----------------------------------------
// XT glue testbench
// Random bus cycles checked against a cycle
// model of decode, EMS map and read-back
// ----------------------------------------
`timescale 1ns/1ns

module tb_xt_glue;
    import xt_glue_pkg::*;

    localparam int CLOCK_PERIOD = 8;
    localparam int RESET_CYCLES = 10;
    localparam int SELECT_RUNS  = 300;
    localparam int EMS_RUNS     = 200;
    localparam int WINDOW_RUNS  = 100;
    localparam int PORT_RUNS    = 150;
    localparam int IDLE_RUNS    = 50;
    // Upper bound on bus cycles over all tests
    localparam int TEST_CYCLES  = SELECT_RUNS + 3 * EMS_RUNS + 3 * (WINDOW_RUNS + 8)
                                  + 3 * PORT_RUNS + IDLE_RUNS + 50;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + TEST_CYCLES) * CLOCK_PERIOD + 1000;

    logic                     clock;
    logic                     reset;
    bus_cycle_t               bus;
    logic                     tandy_video;
    logic                     ems_enabled;
    logic [1:0]               ems_frame;
    io_select_t               selects;
    ems_map_t [EMS_PAGES-1:0] ems_map;
    logic [EMS_PAGES-1:0]     ems_window;
    logic [DATA_W-1:0]        data;
    logic                     data_valid;

    // Model state as of the last rising edge
    ems_map_t [EMS_PAGES-1:0] model_map;
    logic                     model_pend;
    logic [1:0]               model_pend_index;
    ems_map_t                 model_pend_entry;
    logic [DATA_W-1:0]        model_lpt;
    logic [DATA_W-1:0]        model_nmi;
    logic [DATA_W-1:0]        model_data;
    logic                     model_valid;
    logic [8:0]               decoded;
    logic                     ems_hit;
    logic                     lpt_hit;
    logic                     nmi_hit;
    int                       checks_done;
    int                       failures;

    tb_clock_gen u_clock_gen (
        .clock_o (clock),
        .reset_o (reset)
    );

    xt_glue_top u_dut (
        .clock         (clock),
        .reset         (reset),
        .bus_i         (bus),
        .tandy_video_i (tandy_video),
        .ems_enabled_i (ems_enabled),
        .ems_frame_i   (ems_frame),
        .selects_o     (selects),
        .ems_map_o     (ems_map),
        .ems_window_o  (ems_window),
        .data_o        (data),
        .data_valid_o  (data_valid)
    );

    // Block k of 32 bytes pulls select bit 4-k low, dma_n first
    function automatic io_select_t expected_selects(bus_cycle_t b);
        logic [4:0] bits;
        bits = 5'b11111;
        if (!b.address_enable_n && b.address[9:8] == 2'b00
            && !(b.io_read_n && b.io_write_n) && b.address[7:5] < 3'd5) begin
            bits[4 - int'(b.address[7:5])] = 1'b0;
        end
        return io_select_t'(bits);
    endfunction

    function automatic logic [3:0] expected_windows(bus_cycle_t b, logic [1:0] frame,
                                                    ems_map_t [EMS_PAGES-1:0] map);
        logic [3:0] top;
        logic [3:0] hits;
        top  = (frame == 2'd0) ? 4'hA : (frame == 2'd1) ? 4'hC : 4'hD;
        hits = '0;
        for (int k = 0; k < EMS_PAGES; k++) begin
            if (b.io_read_n && b.io_write_n && map[k].enable
                && b.address[19:14] == {top, 2'(k)}) begin
                hits[k] = 1'b1;
            end
        end
        return hits;
    endfunction

    // Bit 8 marks a change, bits 7 to 0 hold the new entry
    function automatic logic [8:0] decode_ems_write(logic [7:0] d);
        if (d == 8'hFF) begin
            return {1'b1, 1'b0, 7'h7F};
        end
        if (d < 8'h80) begin
            return {1'b1, 1'b1, d[6:0]};
        end
        return 9'h000;
    endfunction

    function automatic logic [7:0] ems_readback(ems_map_t e);
        return e.enable ? {1'b0, e.page} : 8'hFF;
    endfunction

    function automatic logic [7:0] random_map_byte();
        return ($urandom_range(0, 3) == 0) ? 8'hFF : 8'($urandom);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks_done++;
        if (actual !== expected) begin
            failures++;
            $display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, actual,
                     expected);
            $display("tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Steps the model over the next rising edge with the inputs now on the bus
    task automatic advance_model();
        ems_hit = !bus.address_enable_n && ems_enabled
                  && bus.address[15:0] >= 16'h0260 && bus.address[15:0] <= 16'h0263;
        lpt_hit = !bus.address_enable_n && bus.address[15:0] == 16'h0378;
        nmi_hit = !bus.address_enable_n && tandy_video
                  && bus.address[15:0] >= 16'h00A0 && bus.address[15:0] <= 16'h00A7;
        model_valid = !bus.io_read_n && (ems_hit || lpt_hit || nmi_hit);
        if (!bus.io_read_n && ems_hit) begin
            model_data = ems_readback(model_map[bus.address[1:0]]);
        end else if (!bus.io_read_n && lpt_hit) begin
            model_data = model_lpt;
        end else if (!bus.io_read_n && nmi_hit) begin
            model_data = model_nmi;
        end else begin
            model_data = '0;
        end
        if (model_pend) begin
            model_map[model_pend_index] = model_pend_entry;
        end
        decoded          = decode_ems_write(bus.write_data);
        model_pend       = ems_hit && !bus.io_write_n && decoded[8];
        model_pend_index = bus.address[1:0];
        model_pend_entry = decoded[7:0];
        if (lpt_hit && !bus.io_write_n) begin
            model_lpt = bus.write_data;
        end
        if (nmi_hit && !bus.io_write_n) begin
            model_nmi = bus.write_data;
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clock) begin
        if (reset) begin
            model_map   = '0;
            model_pend  = 1'b0;
            model_lpt   = 8'hFF;
            model_nmi   = 8'hFF;
            model_data  = '0;
            model_valid = 1'b0;
        end else begin
            check_value(32'(selects), 32'(expected_selects(bus)), "chip selects");
            check_value(32'(ems_window), 32'(expected_windows(bus, ems_frame, model_map)),
                        "window hits");
            check_value(32'(ems_map), 32'(model_map), "EMS map");
            check_value(32'(data_valid), 32'(model_valid), "read-back valid");
            check_value(32'(data), 32'(model_data), "read-back data");
            advance_model();
        end
    end

    task automatic bus_cycle(input logic [19:0] address, input logic [7:0] write_data,
                             input logic read_n, input logic write_n, input logic aen_n);
        @(posedge clock);
        bus <= '{address: address, write_data: write_data, io_read_n: read_n,
                 io_write_n: write_n, address_enable_n: aen_n};
    endtask

    task automatic io_write(input logic [19:0] address, input logic [7:0] value);
        bus_cycle(address, value, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic io_read(input logic [19:0] address);
        bus_cycle(address, 8'h00, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic set_mode(input logic tandy, input logic ems_on, input logic [1:0] frame);
        bus_cycle(20'h00000, 8'h00, 1'b1, 1'b1, 1'b1);
        tandy_video <= tandy;
        ems_enabled <= ems_on;
        ems_frame   <= frame;
    endtask

    initial begin
        logic [19:0] address;
        logic [3:0]  top;
        void'($urandom(32'hfea734ee));
        checks_done = 0;
        failures    = 0;
        bus         = '{address: '0, write_data: '0, io_read_n: 1'b1, io_write_n: 1'b1,
                        address_enable_n: 1'b1};
        tandy_video = 1'b0;
        ems_enabled = 1'b0;
        ems_frame   = 2'd0;
        wait (!reset);

        // Reset values of both registers
        set_mode(1'b1, 1'b1, 2'd0);
        io_read(20'h00378);
        io_read(20'h000A0);

        for (int i = 0; i < SELECT_RUNS; i++) begin
            bus_cycle(20'($urandom_range(0, 1023)), 8'($urandom), 1'($urandom),
                      1'($urandom), 1'($urandom));
        end

        set_mode(1'b1, 1'b1, 2'd0);
        for (int i = 0; i < EMS_RUNS; i++) begin
            io_write(20'h00260 + 20'($urandom_range(0, 3)), random_map_byte());
            io_read(20'h00260 + 20'($urandom_range(0, 3)));
        end
        // Writes with EMS off must leave the map alone
        set_mode(1'b1, 1'b0, 2'd0);
        for (int i = 0; i < EMS_RUNS / 4; i++) begin
            io_write(20'h00260 + 20'($urandom_range(0, 3)), random_map_byte());
        end
        set_mode(1'b1, 1'b1, 2'd0);
        for (int k = 0; k < EMS_PAGES; k++) begin
            io_read(20'h00260 + 20'(k));
        end

        for (int f = 0; f < 3; f++) begin
            set_mode(1'b1, 1'b1, 2'(f));
            for (int k = 0; k < EMS_PAGES; k++) begin
                io_write(20'h00260 + 20'(k), random_map_byte());
            end
            for (int i = 0; i < WINDOW_RUNS; i++) begin
                case ($urandom_range(0, 3))
                    0:       top = 4'hA;
                    1:       top = 4'hC;
                    2:       top = 4'hD;
                    default: top = 4'($urandom);
                endcase
                address = {top, 2'($urandom), 14'($urandom)};
                // One in four carries an I/O strobe
                if ($urandom_range(0, 3) == 0) begin
                    bus_cycle(address, 8'h00, 1'b0, 1'b1, 1'b1);
                end else begin
                    bus_cycle(address, 8'h00, 1'b1, 1'b1, 1'b0);
                end
            end
        end

        for (int i = 0; i < PORT_RUNS; i++) begin
            if (i % 25 == 0) begin
                set_mode(1'($urandom), 1'b1, 2'd0);
            end
            address = ($urandom_range(0, 1) == 0) ? 20'h00378
                                                  : 20'h000A0 + 20'($urandom_range(0, 7));
            io_write(address, 8'($urandom));
            io_read(address);
        end

        set_mode(1'b1, 1'b1, 2'd0);
        for (int i = 0; i < IDLE_RUNS; i++) begin
            address = 20'($urandom_range(0, 1023));
            while ((address >= 20'h00260 && address <= 20'h00263) || address == 20'h00378
                   || (address >= 20'h000A0 && address <= 20'h000A7)) begin
                address = 20'($urandom_range(0, 1023));
            end
            io_read(address);
        end
        bus_cycle(20'h00000, 8'h00, 1'b1, 1'b1, 1'b1);
        repeat (2) @(posedge clock);
        @(negedge clock);

        if (failures == 0 && checks_done > 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "no checks ran or a check failed");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: list.f
source/xt_glue_pkg.sv
source/xt_io_decoder.sv
source/xt_ems_mapper.sv
source/xt_port_registers.sv
source/xt_bus_readback.sv
source/xt_glue_top.sv
test/tb_clock_gen.sv
test/tb_xt_glue.sv

// File: run.sh
#!/bin/sh
# Build and run the XT glue testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -f list.f --top-module tb_xt_glue \
    -Mdir "$BUILD" -o sim_xt_glue
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/sim_xt_glue" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
